/* rtl/rename_pkg.sv */
/* Shared widths and types for register renaming. Sized for 32 architectural
   and 64 physical registers, so the free list holds 32 entries */
`default_nettype none

package rename_pkg;

  // Register file sizes
  localparam int NUM_AREGS = 32;
  localparam int NUM_PREGS = 64;

  // Field widths
  localparam int AREG_W   = 5;
  localparam int PREG_W   = 6;
  localparam int FL_PTR_W = 6;
  localparam int OPC_W    = 7;

  // Architectural register index
  typedef logic [AREG_W-1:0] areg_t;

  // Physical register index
  typedef logic [PREG_W-1:0] preg_t;

  // Free-list pointer
  // Low bits pick the entry, top bit is the wrap flag
  typedef logic [FL_PTR_W-1:0] fl_ptr_t;

  // RV32 instruction field positions
  localparam int OPC_LSB = 0;
  localparam int RD_LSB  = 7;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;

  // Opcodes without a destination register
  localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
  localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;

endpackage

`default_nettype wire

/* rtl/rename_if.sv */
/* One decoded instruction from decode to allocate. hold is the only
   signal the allocate side drives */
`default_nettype none

interface rename_if;
  import rename_pkg::*;

  // Decoded instruction
  logic  valid;
  areg_t rs1;
  areg_t rs2;
  areg_t rd;
  // Writes a register other than x0
  logic  has_dest;

  // Allocate stage is stalled
  logic  hold;

  modport src (
    output valid, rs1, rs2, rd, has_dest,
    input  hold
  );

  modport dst (
    input  valid, rs1, rs2, rd, has_dest,
    output hold
  );

endinterface

`default_nettype wire

/* rtl/rename_decode_stage.sv */
/* First rename stage. Field extraction is RV32 only; compressed
   instructions are not handled */
`default_nettype none

module rename_decode_stage (
  input  logic        clk,
  input  logic        rst,
  input  logic        recover_en_i,
  input  logic        in_valid_i,
  input  logic [31:0] in_instr_i,
  output logic        in_ready_o,
  rename_if.src       dec
);
  import rename_pkg::*;

  logic [OPC_W-1:0] opcode;
  areg_t            rs1_next;
  areg_t            rs2_next;
  areg_t            rd_next;
  logic             has_dest_next;

  logic  valid_q;
  areg_t rs1_q;
  areg_t rs2_q;
  areg_t rd_q;
  logic  has_dest_q;

  // Field extraction from standard RV32 positions
  assign opcode   = in_instr_i[OPC_LSB +: OPC_W];
  assign rs1_next = in_instr_i[RS1_LSB +: AREG_W];
  assign rs2_next = in_instr_i[RS2_LSB +: AREG_W];
  assign rd_next  = in_instr_i[RD_LSB +: AREG_W];

  // Stores and branches have no rd, x0 writes are dropped
  assign has_dest_next = (opcode != OPC_STORE) &&
                         (opcode != OPC_BRANCH) &&
                         (rd_next != '0);

  // Blocked only while a stalled instruction sits here
  assign in_ready_o = !(valid_q && dec.hold);

  // Valid bit
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (recover_en_i) begin
      // Flush on recovery
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Decoded fields
  always_ff @(posedge clk) begin
    if (in_ready_o) begin
      rs1_q      <= rs1_next;
      rs2_q      <= rs2_next;
      rd_q       <= rd_next;
      has_dest_q <= has_dest_next;
    end
  end

  assign dec.valid    = valid_q;
  assign dec.rs1      = rs1_q;
  assign dec.rs2      = rs2_q;
  assign dec.rd       = rd_q;
  assign dec.has_dest = has_dest_q;

endmodule

`default_nettype wire

/* rtl/free_list.sv */
/* Circular queue of free physical registers, full at reset. FL_DEPTH must be
   a power of two equal to NUM_PREGS - NUM_AREGS; retires into a full list are lost */
`default_nettype none

module free_list #(
  parameter int FL_DEPTH = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                dispatch_en_i,
  input  logic                retire_en_i,
  input  logic                recover_en_i,
  input  rename_pkg::preg_t   retire_preg_i,
  input  rename_pkg::fl_ptr_t recover_head_i,
  output logic                free_vld_o,
  output rename_pkg::preg_t   free_preg_o,
  output rename_pkg::fl_ptr_t cur_head_o
);
  import rename_pkg::*;

  localparam int IDX_W = $clog2(FL_DEPTH);

  preg_t fl_mem [FL_DEPTH];

  // Pointers carry one extra wrap bit
  logic [IDX_W:0] head_q;
  logic [IDX_W:0] tail_q;
  logic [IDX_W:0] occupancy;

  logic empty;
  logic full;
  logic pop;
  logic bypass;
  logic push;

  // Occupancy from pointers, so a head reload stays consistent
  assign occupancy = tail_q - head_q;
  assign empty     = (occupancy == '0);
  assign full      = (occupancy == (IDX_W+1)'(FL_DEPTH));

  // Normal read from the head
  assign pop    = dispatch_en_i && !empty;
  // Empty list, retiring register goes straight out
  // Not taken on recovery, since the allocation is discarded there
  assign bypass = dispatch_en_i && empty && retire_en_i && !recover_en_i;
  // Retire write to the tail, unless consumed by the bypass
  assign push   = retire_en_i && !full && !bypass;

  assign free_vld_o  = dispatch_en_i && (!empty || retire_en_i);
  assign free_preg_o = empty ? retire_preg_i : fl_mem[head_q[IDX_W-1:0]];
  // Head before this cycle's allocation
  assign cur_head_o  = fl_ptr_t'(head_q);

  // Tail and storage
  always_ff @(posedge clk) begin
    if (rst) begin
      // Registers above the architectural ones start out free
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_mem[i] <= preg_t'(NUM_AREGS + i);
      end
      // Wrap bit set, list starts full
      tail_q <= (IDX_W+1)'(FL_DEPTH);
    end else if (push) begin
      fl_mem[tail_q[IDX_W-1:0]] <= retire_preg_i;
      tail_q                    <= tail_q + 1'b1;
    end
  end

  // Head, recovery wins over an allocation
  always_ff @(posedge clk) begin
    if (rst) begin
      head_q <= '0;
    end else if (recover_en_i) begin
      head_q <= recover_head_i[IDX_W:0];
    end else if (pop) begin
      head_q <= head_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/map_table.sv */
/* Speculative and retirement rename maps, identity at reset. Writes to x0
   are dropped, so x0 always maps to physical register 0 */
`default_nettype none

module map_table (
  input  logic              clk,
  input  logic              rst,
  input  logic              recover_en_i,
  input  rename_pkg::areg_t rd_rs1_i,
  input  rename_pkg::areg_t rd_rs2_i,
  input  rename_pkg::areg_t rd_rd_i,
  output rename_pkg::preg_t ps1_o,
  output rename_pkg::preg_t ps2_o,
  output rename_pkg::preg_t old_pd_o,
  input  logic              wr_en_i,
  input  rename_pkg::areg_t wr_areg_i,
  input  rename_pkg::preg_t wr_preg_i,
  input  logic              retire_en_i,
  input  rename_pkg::areg_t retire_areg_i,
  input  rename_pkg::preg_t retire_preg_i
);
  import rename_pkg::*;

  // Speculative map, read and written at rename
  preg_t spec_map [NUM_AREGS];
  // Retirement map, written at retire
  preg_t arch_map [NUM_AREGS];
  // Retirement map with this cycle's retire applied
  preg_t arch_next [NUM_AREGS];

  logic spec_wr;
  logic arch_wr;

  assign spec_wr = wr_en_i && (wr_areg_i != '0);
  assign arch_wr = retire_en_i && (retire_areg_i != '0);

  // Source lookups and previous mapping of rd
  assign ps1_o    = spec_map[rd_rs1_i];
  assign ps2_o    = spec_map[rd_rs2_i];
  assign old_pd_o = spec_map[rd_rd_i];

  always_comb begin
    arch_next = arch_map;
    if (arch_wr) begin
      arch_next[retire_areg_i] = retire_preg_i;
    end
  end

  // Retirement map
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_AREGS; i++) begin
        arch_map[i] <= preg_t'(i);
      end
    end else begin
      arch_map <= arch_next;
    end
  end

  // Speculative map
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_AREGS; i++) begin
        spec_map[i] <= preg_t'(i);
      end
    end else if (recover_en_i) begin
      // Whole copy, includes a same-cycle retire
      // Any rename write this cycle is lost
      spec_map <= arch_next;
    end else if (spec_wr) begin
      spec_map[wr_areg_i] <= wr_preg_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/rename_alloc_stage.sv */
/* Second rename stage. Stalls a destination instruction until the free
   list has a register; non-destination ones pass with out_pd_o zero */
`default_nettype none

module rename_alloc_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                recover_en_i,
  rename_if.dst               dec,
  output logic                dispatch_en_o,
  input  logic                free_vld_i,
  input  rename_pkg::preg_t   free_preg_i,
  input  rename_pkg::fl_ptr_t cur_head_i,
  output rename_pkg::areg_t   rd_rs1_o,
  output rename_pkg::areg_t   rd_rs2_o,
  output rename_pkg::areg_t   rd_rd_o,
  input  rename_pkg::preg_t   ps1_i,
  input  rename_pkg::preg_t   ps2_i,
  input  rename_pkg::preg_t   old_pd_i,
  output logic                wr_en_o,
  output rename_pkg::areg_t   wr_areg_o,
  output rename_pkg::preg_t   wr_preg_o,
  output logic                out_valid_o,
  output logic                out_has_dest_o,
  output rename_pkg::preg_t   out_pd_o,
  output rename_pkg::preg_t   out_ps1_o,
  output rename_pkg::preg_t   out_ps2_o,
  output rename_pkg::preg_t   out_old_pd_o,
  output rename_pkg::fl_ptr_t out_head_o
);
  import rename_pkg::*;

  logic  stall;
  logic  proceed;
  preg_t pd_next;

  // Ask for a register only when rd is real
  assign dispatch_en_o = dec.valid && dec.has_dest;
  assign stall         = dispatch_en_o && !free_vld_i;
  assign proceed       = dec.valid && !stall;
  assign dec.hold      = stall;

  // Map lookups straight from the decode register
  assign rd_rs1_o = dec.rs1;
  assign rd_rs2_o = dec.rs2;
  assign rd_rd_o  = dec.rd;

  // New mapping for rd once a register is granted
  assign wr_en_o   = dispatch_en_o && free_vld_i;
  assign wr_areg_o = dec.rd;
  assign wr_preg_o = free_preg_i;

  assign pd_next = dec.has_dest ? free_preg_i : '0;

  // Output strobe, one pulse per renamed instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
    end else if (recover_en_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= proceed;
    end
  end

  // Renamed payload
  always_ff @(posedge clk) begin
    if (proceed) begin
      out_has_dest_o <= dec.has_dest;
      out_pd_o       <= pd_next;
      out_ps1_o      <= ps1_i;
      out_ps2_o      <= ps2_i;
      // Freed when this instruction retires
      out_old_pd_o   <= old_pd_i;
      // Recovery point for this instruction
      out_head_o     <= cur_head_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/rename_top.sv */
/* Register rename subsystem, two cycles from accept to output.
   Each retire must return exactly one register to the free list */
`default_nettype none

module rename_top #(
  parameter int FL_DEPTH = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  input  logic [31:0]         in_instr_i,
  output logic                in_ready_o,
  input  logic                retire_en_i,
  input  rename_pkg::areg_t   retire_areg_i,
  input  rename_pkg::preg_t   retire_preg_i,
  input  rename_pkg::preg_t   retire_old_preg_i,
  input  logic                recover_en_i,
  input  rename_pkg::fl_ptr_t recover_head_i,
  output logic                out_valid_o,
  output logic                out_has_dest_o,
  output rename_pkg::preg_t   out_pd_o,
  output rename_pkg::preg_t   out_ps1_o,
  output rename_pkg::preg_t   out_ps2_o,
  output rename_pkg::preg_t   out_old_pd_o,
  output rename_pkg::fl_ptr_t out_head_o
);
  import rename_pkg::*;

  // Free list must cover exactly the non-architectural registers
  if (FL_DEPTH != NUM_PREGS - NUM_AREGS || (FL_DEPTH & (FL_DEPTH - 1)) != 0) begin : g_depth_chk
    $error("FL_DEPTH must be a power of two equal to NUM_PREGS - NUM_AREGS");
  end

  rename_if dec_if ();

  logic    dispatch_en;
  logic    free_vld;
  preg_t   free_preg;
  fl_ptr_t cur_head;
  areg_t   rd_rs1;
  areg_t   rd_rs2;
  areg_t   rd_rd;
  preg_t   ps1;
  preg_t   ps2;
  preg_t   old_pd;
  logic    wr_en;
  areg_t   wr_areg;
  preg_t   wr_preg;

  rename_decode_stage u_decode (
    .clk          (clk),
    .rst          (rst),
    .recover_en_i (recover_en_i),
    .in_valid_i   (in_valid_i),
    .in_instr_i   (in_instr_i),
    .in_ready_o   (in_ready_o),
    .dec          (dec_if.src)
  );

  rename_alloc_stage u_alloc (
    .clk (clk), .rst (rst), .recover_en_i (recover_en_i), .dec (dec_if.dst),
    .dispatch_en_o (dispatch_en), .free_vld_i (free_vld),
    .free_preg_i (free_preg), .cur_head_i (cur_head),
    .rd_rs1_o (rd_rs1), .rd_rs2_o (rd_rs2), .rd_rd_o (rd_rd),
    .ps1_i (ps1), .ps2_i (ps2), .old_pd_i (old_pd),
    .wr_en_o (wr_en), .wr_areg_o (wr_areg), .wr_preg_o (wr_preg),
    .out_valid_o (out_valid_o), .out_has_dest_o (out_has_dest_o),
    .out_pd_o (out_pd_o), .out_ps1_o (out_ps1_o), .out_ps2_o (out_ps2_o),
    .out_old_pd_o (out_old_pd_o), .out_head_o (out_head_o)
  );

  // Superseded register goes back to the free list
  free_list #(.FL_DEPTH (FL_DEPTH)) u_free_list (
    .clk (clk), .rst (rst), .dispatch_en_i (dispatch_en),
    .retire_en_i (retire_en_i), .recover_en_i (recover_en_i),
    .retire_preg_i (retire_old_preg_i), .recover_head_i (recover_head_i),
    .free_vld_o (free_vld), .free_preg_o (free_preg), .cur_head_o (cur_head)
  );

  map_table u_map_table (
    .clk (clk), .rst (rst), .recover_en_i (recover_en_i),
    .rd_rs1_i (rd_rs1), .rd_rs2_i (rd_rs2), .rd_rd_i (rd_rd),
    .ps1_o (ps1), .ps2_o (ps2), .old_pd_o (old_pd),
    .wr_en_i (wr_en), .wr_areg_i (wr_areg), .wr_preg_i (wr_preg),
    .retire_en_i (retire_en_i), .retire_areg_i (retire_areg_i),
    .retire_preg_i (retire_preg_i)
  );

endmodule

`default_nettype wire

/* bench/rename_tb.sv */
/* Testbench for rename_top. Retires follow program order, and recovery only
   targets a point where every older instruction has retired */
`default_nettype none

module rename_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rename_pkg::*;

  // Bench copies of the RV32 opcodes
  localparam logic [6:0] ALU_OPC    = 7'b0110011;
  localparam logic [6:0] IMM_OPC    = 7'b0010011;
  localparam logic [6:0] STORE_OPC  = 7'b0100011;
  localparam logic [6:0] BRANCH_OPC = 7'b1100011;
  localparam int FREE_N = NUM_PREGS - NUM_AREGS;
  // Instructions of all phases, doubled to cover the retires
  localparam int PLANNED_OPS = 2 * (8 + 16 + 24 + FREE_N + 2 + 10 + 8 + FREE_N);

  typedef struct packed {
    areg_t       rs1;
    areg_t       rs2;
    areg_t       rd;
    logic        has_dest;
    logic [31:0] cyc_no;
  } pend_t;

  typedef struct packed {
    areg_t rd;
    preg_t pd;
    preg_t old_pd;
  } done_t;

  logic        clk, rst, in_valid_i, in_ready_o;
  logic [31:0] in_instr_i;
  logic        retire_en_i, recover_en_i;
  areg_t       retire_areg_i;
  preg_t       retire_preg_i, retire_old_preg_i;
  fl_ptr_t     recover_head_i, out_head_o;
  logic        out_valid_o, out_has_dest_o;
  preg_t       out_pd_o, out_ps1_o, out_ps2_o, out_old_pd_o;

  // Reference model
  preg_t       spec_m [NUM_AREGS];
  preg_t       arch_m [NUM_AREGS];
  preg_t       fq [FREE_N];
  fl_ptr_t     m_head, m_tail;
  pend_t       pend_q [$];
  done_t       done_q [$];
  logic [31:0] instr_q [$];

  int unsigned cyc;
  int unsigned retire_budget;
  logic        strict_lat, acc, rec_req;
  fl_ptr_t     rec_head;
  integer      seed = 32'hdc99;

  rename_top u_rename_top (.*);

  always #50 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
    else fail_run($sformatf("MISMATCH %s expected 0x%0h got 0x%0h", name, exp, got));
  endtask

  // No output right after a flush
  assert property (@(posedge clk) disable iff (rst) recover_en_i |=> !out_valid_o)
    else fail_run("Output valid in the cycle after recovery");
  // Idle and ready once reset drops
  assert property (@(posedge clk) $fell(rst) |-> (in_ready_o && !out_valid_o))
    else fail_run("Wrong ready or valid level after reset");

  // mode 0 mixed, 1 chained on previous rd, 2 destination only
  task automatic push_random(input int n, input int mode);
    logic [6:0]  opc;
    logic [31:0] rnd;
    areg_t       rd, rs1, rs2, prev_rd;
    prev_rd = 5'd1;
    for (int i = 0; i < n; i++) begin
      rnd = $random(seed);
      case (rnd[7:0] % 6)
        3: opc = IMM_OPC;
        4: opc = STORE_OPC;
        5: opc = BRANCH_OPC;
        default: opc = ALU_OPC;
      endcase
      rd  = rnd[12:8];
      rs1 = rnd[17:13];
      rs2 = rnd[22:18];
      if (mode == 1) begin
        rs1 = prev_rd;
      end
      if (mode == 2) begin
        opc = ALU_OPC;
        rd  = (rd == '0) ? 5'd7 : rd;
      end
      prev_rd = rd;
      instr_q.push_back({7'b0, rs2, rs1, 3'b0, rd, opc});
    end
  endtask

  // Compare the outcome of the last rising edge, then advance the model
  task automatic check_edge();
    pend_t p;
    preg_t exp_pd;
    logic  bypass;
    bypass = 1'b0;
    if (out_valid_o) begin
      assert (pend_q.size() != 0)
      else fail_run("Output valid with no instruction in flight");
      p = pend_q.pop_front();
      if (strict_lat) begin
        check_value("latency", 32'd2, cyc - p.cyc_no);
      end
      exp_pd = '0;
      if (p.has_dest && m_head != m_tail) begin
        exp_pd = fq[m_head[4:0]];
      end else if (p.has_dest) begin
        // Retiring register goes straight out of an empty list
        assert (retire_en_i)
        else fail_run("Destination allocated from an empty free list");
        exp_pd = retire_old_preg_i;
        bypass = 1'b1;
      end
      check_value("out_has_dest_o", 32'(p.has_dest), 32'(out_has_dest_o));
      check_value("out_pd_o", 32'(exp_pd), 32'(out_pd_o));
      check_value("out_ps1_o", 32'(spec_m[p.rs1]), 32'(out_ps1_o));
      check_value("out_ps2_o", 32'(spec_m[p.rs2]), 32'(out_ps2_o));
      check_value("out_old_pd_o", 32'(spec_m[p.rd]), 32'(out_old_pd_o));
      check_value("out_head_o", 32'(m_head), 32'(out_head_o));
      if (p.has_dest) begin
        if (!bypass) begin
          m_head++;
        end
        done_q.push_back(done_t'{p.rd, exp_pd, spec_m[p.rd]});
        spec_m[p.rd] = exp_pd;
      end
    end
    if (retire_en_i) begin
      arch_m[retire_areg_i] = retire_preg_i;
      if (!bypass) begin
        fq[m_tail[4:0]] = retire_old_preg_i;
        m_tail++;
      end
    end
    // Retire first, then the flush
    if (recover_en_i) begin
      pend_q.delete();
      done_q.delete();
      spec_m = arch_m;
      m_head = recover_head_i;
    end
  endtask

  task automatic step_cycle();
    @(negedge clk);
    cyc++;
    check_edge();
    if (acc) begin
      void'(instr_q.pop_front());
    end
    retire_en_i    = 1'b0;
    recover_en_i   = rec_req;
    recover_head_i = rec_head;
    rec_req        = 1'b0;
    in_valid_i     = !recover_en_i && (instr_q.size() > 0);
    if (in_valid_i) begin
      in_instr_i = instr_q[0];
    end
    if (!recover_en_i && retire_budget > 0 && done_q.size() > 0) begin
      retire_en_i       = 1'b1;
      retire_areg_i     = done_q[0].rd;
      retire_preg_i     = done_q[0].pd;
      retire_old_preg_i = done_q[0].old_pd;
      void'(done_q.pop_front());
      retire_budget--;
    end
    // Ready settles from the inputs just driven
    #1;
    // Ready drops only while the free list is empty and nothing retires
    assert (in_ready_o || (m_head == m_tail && !retire_en_i))
    else fail_run("Input not ready although a free register is available");
    acc = in_valid_i && in_ready_o;
    if (acc) begin
      pend_q.push_back(pend_t'{in_instr_i[19:15], in_instr_i[24:20], in_instr_i[11:7],
                              (in_instr_i[6:0] != STORE_OPC) && (in_instr_i[6:0] != BRANCH_OPC)
                              && (in_instr_i[11:7] != '0), cyc});
    end
  endtask

  task automatic run_until_idle();
    while (instr_q.size() > 0 || pend_q.size() > 0 ||
           (retire_budget > 0 && done_q.size() > 0)) begin
      step_cycle();
    end
    repeat (2) step_cycle();
  endtask

  // Watchdog
  initial begin
    repeat (PLANNED_OPS * 20) @(posedge clk);
    fail_run("Timeout, the tests did not finish in time");
  end

  initial begin
    clk               = 1'b0;
    rst               = 1'b1;
    in_valid_i        = 1'b0;
    in_instr_i        = '0;
    retire_en_i       = 1'b0;
    retire_areg_i     = '0;
    retire_preg_i     = '0;
    retire_old_preg_i = '0;
    recover_en_i      = 1'b0;
    recover_head_i    = '0;
    acc               = 1'b0;
    rec_req           = 1'b0;
    rec_head          = '0;
    strict_lat        = 1'b1;
    retire_budget     = 0;
    cyc               = 0;
    for (int i = 0; i < NUM_AREGS; i++) begin
      spec_m[i] = preg_t'(i);
      arch_m[i] = preg_t'(i);
    end
    for (int i = 0; i < FREE_N; i++) begin
      fq[i] = preg_t'(NUM_AREGS + i);
    end
    m_head = '0;
    m_tail = fl_ptr_t'(FREE_N);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Identity sources, destinations from 32 upward
    push_random(8, 0);
    run_until_idle();
    push_random(16, 1);
    run_until_idle();
    // Retire everything while renaming so the list ends full
    retire_budget = 10000;
    push_random(24, 0);
    run_until_idle();
    retire_budget = 0;
    // Drain the free list and stall
    strict_lat = 1'b0;
    push_random(FREE_N + 2, 2);
    while (m_head != m_tail) begin
      step_cycle();
    end
    repeat (4) step_cycle();
    check_value("in_ready_o", 32'd0, 32'(in_ready_o));
    check_value("out_valid_o", 32'd0, 32'(out_valid_o));
    // Two retires feed the two stalled instructions
    retire_budget = 2;
    run_until_idle();
    strict_lat = 1'b1;
    retire_budget = 10000;
    run_until_idle();
    retire_budget = 0;
    // Flush back to the head of the first new output
    push_random(10, 0);
    while (!out_valid_o) begin
      step_cycle();
    end
    rec_head = out_head_o;
    repeat (3) step_cycle();
    rec_req = 1'b1;
    repeat (2) step_cycle();
    push_random(8, 0);
    run_until_idle();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* rename_top.f */
rtl/rename_pkg.sv
rtl/rename_if.sv
rtl/rename_decode_stage.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/rename_alloc_stage.sv
rtl/rename_top.sv
bench/rename_tb.sv

/* Bender.yml */
package:
  name: rename_top

sources:
  - rtl/rename_pkg.sv
  - rtl/rename_if.sv
  - rtl/rename_decode_stage.sv
  - rtl/free_list.sv
  - rtl/map_table.sv
  - rtl/rename_alloc_stage.sv
  - rtl/rename_top.sv
  - target: test
    files:
      - bench/rename_tb.sv
